//--- lockstep_params.svh
/*
 Shared constants of the lockstep checker.
 Included by the package, the interface and every RTL module that needs
 a width, the lockstep offset or one of the fixed core addresses.
*/

`ifndef LOCKSTEP_PARAMS_SVH
`define LOCKSTEP_PARAMS_SVH

// Cycles the shadow core runs behind the main core, 2 or more
`define LS_OFFSET 2
`define LS_OFFSET_W ($clog2(`LS_OFFSET))

`define LS_XLEN 32
`define LS_INTG_W 7

// Fetch start and the store window
`define LS_BOOT_ADDR 32'h0000_0100
`define LS_DATA_BASE 32'h0010_0000

`endif

//--- lockstep_pkg.sv
/*
 Types and functions for bus integrity.
 Holds the 39-bit codeword view of a bus word and the Hsiao (39,32)
 check-bit encoder used on both the checker and the testbench side.
*/

`include "lockstep_params.svh"

package lockstep_pkg;

  // One codeword, seen either as a flat vector or as check bits plus data
  typedef union packed {
    logic [`LS_INTG_W+`LS_XLEN-1:0] raw;
    struct packed {
      logic [`LS_INTG_W-1:0] intg;
      logic [`LS_XLEN-1:0]   data;
    } fields;
  } intg_word_u;

  // Data columns of the parity matrix, one row per check bit
  localparam logic [`LS_INTG_W-1:0][`LS_XLEN-1:0] intg_mask = {
    32'h9850_5586,
    32'h2DCC_624C,
    32'hC2C1_323B,
    32'h3123_4ED1,
    32'h413D_89AA,
    32'hDEBA_8050,
    32'h2606_BD25
  };

  function automatic logic [`LS_INTG_W-1:0] intg_encode(logic [`LS_XLEN-1:0] data);
    logic [`LS_INTG_W-1:0] intg;
    for (int i = 0; i < `LS_INTG_W; i++) begin
      intg[i] = ^(data & intg_mask[i]);
    end
    return intg;
  endfunction

endpackage

//--- core_bus_if.sv
/*
 Request side of one core's instruction and data bus.
 The core modport is driven by a bus master, the cmp modport is read by
 the lockstep comparator. Responses travel as plain ports.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

interface core_bus_if;

  logic                   instr_req;
  logic [`LS_XLEN-1:0]    instr_addr;
  logic                   data_req;
  logic                   data_we;
  logic [`LS_XLEN/8-1:0]  data_be;
  logic [`LS_XLEN-1:0]    data_addr;
  logic [`LS_XLEN-1:0]    data_wdata;

  modport core (
    output instr_req,
    output instr_addr,
    output data_req,
    output data_we,
    output data_be,
    output data_addr,
    output data_wdata
  );

  modport cmp (
    input instr_req,
    input instr_addr,
    input data_req,
    input data_we,
    input data_be,
    input data_addr,
    input data_wdata
  );

endinterface

//--- shadow_reset_ctrl.sv
/*
 Reset release for the shadow core.
 Holds the shadow core in reset for the lockstep offset after the system
 reset and enables the output compare one cycle later.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module shadow_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic cmp_en_o
);

  localparam int unsigned cnt_w = `LS_OFFSET_W;

  logic [cnt_w-1:0] cnt_d, cnt_q;
  logic             set_d, set_q;
  logic             cmp_en_q;

  // Saturates at offset - 1
  assign set_d = (cnt_q == cnt_w'(`LS_OFFSET - 1));
  assign cnt_d = set_d ? cnt_q : cnt_q + cnt_w'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      set_q    <= 1'b0;
      cmp_en_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      set_q    <= set_d;
      cmp_en_q <= set_q;
    end
  end

  assign rst_shadow_no = set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

//--- shadow_input_delay.sv
/*
 Bus response delay line for the shadow core.
 Every response is presented to the shadow core the lockstep offset later.
 The first stage, joined with the registered check bits, feeds the
 integrity check as two codewords with their rvalid qualifiers.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module shadow_input_delay (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [`LS_XLEN-1:0]       instr_rdata_i,
  input  logic [`LS_INTG_W-1:0]     instr_rdata_intg_i,
  input  logic                      instr_err_i,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [`LS_XLEN-1:0]       data_rdata_i,
  input  logic [`LS_INTG_W-1:0]     data_rdata_intg_i,
  input  logic                      data_err_i,
  input  logic                      fetch_enable_i,
  output logic                      instr_gnt_dly_o,
  output logic                      instr_rvalid_dly_o,
  output logic [`LS_XLEN-1:0]       instr_rdata_dly_o,
  output logic                      instr_err_dly_o,
  output logic                      data_gnt_dly_o,
  output logic                      data_rvalid_dly_o,
  output logic [`LS_XLEN-1:0]       data_rdata_dly_o,
  output logic                      data_err_dly_o,
  output logic                      fetch_enable_dly_o,
  output lockstep_pkg::intg_word_u  instr_word_o,
  output lockstep_pkg::intg_word_u  data_word_o,
  output logic                      instr_chk_valid_o,
  output logic                      data_chk_valid_o
);

  localparam int unsigned xlen  = `LS_XLEN;
  localparam int unsigned dly_w = 2 * xlen + 7;
  localparam int unsigned first = `LS_OFFSET - 1;

  logic [dly_w-1:0]                  dly_in;
  logic [`LS_OFFSET-1:0][dly_w-1:0]  dly_q;
  logic [`LS_INTG_W-1:0]             instr_intg_q, data_intg_q;

  // Read data and rvalids at the bottom, sliced out of the first stage
  assign dly_in = {instr_gnt_i, instr_err_i, data_gnt_i, data_err_i, fetch_enable_i,
                   instr_rvalid_i, data_rvalid_i, instr_rdata_i, data_rdata_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_q <= '0;
    end else begin
      for (int i = 0; i < `LS_OFFSET - 1; i++) begin
        dly_q[i] <= dly_q[i+1];
      end
      dly_q[first] <= dly_in;
    end
  end

  always_ff @(posedge clk_i) begin
    instr_intg_q <= instr_rdata_intg_i;
    data_intg_q  <= data_rdata_intg_i;
  end

  assign {instr_gnt_dly_o, instr_err_dly_o, data_gnt_dly_o, data_err_dly_o,
          fetch_enable_dly_o, instr_rvalid_dly_o, data_rvalid_dly_o,
          instr_rdata_dly_o, data_rdata_dly_o} = dly_q[0];

  always_comb begin
    instr_word_o.fields.intg = instr_intg_q;
    instr_word_o.fields.data = dly_q[first][2*xlen-1:xlen];
    data_word_o.fields.intg  = data_intg_q;
    data_word_o.fields.data  = dly_q[first][xlen-1:0];
  end

  assign instr_chk_valid_o = dly_q[first][2*xlen+1];
  assign data_chk_valid_o  = dly_q[first][2*xlen];

endmodule

//--- shadow_core.sv
/*
 Fetch-and-store bus master, run as the shadow copy of the main core.
 Fetches one word, stores it to the fetch address ORed with the data base,
 then fetches the next word. A fetch error skips the store.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module shadow_core (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic [`LS_XLEN-1:0]  instr_rdata_i,
  input  logic                 instr_err_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 fetch_enable_i,
  core_bus_if.core             bus
);

  localparam logic [1:0] st_fetch_req  = 2'd0;
  localparam logic [1:0] st_fetch_wait = 2'd1;
  localparam logic [1:0] st_store_req  = 2'd2;
  localparam logic [1:0] st_store_wait = 2'd3;

  logic [1:0]           state_d, state_q;
  logic [`LS_XLEN-1:0]  pc_q, fetch_addr_q, wdata_q;
  logic                 fetch_req, store_req, fetch_ok;

  assign fetch_req = (state_q == st_fetch_req) && fetch_enable_i;
  assign store_req = (state_q == st_store_req);
  assign fetch_ok  = (state_q == st_fetch_wait) && instr_rvalid_i && !instr_err_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_fetch_req: begin
        if (fetch_req && instr_gnt_i) state_d = st_fetch_wait;
      end
      st_fetch_wait: begin
        if (instr_rvalid_i) state_d = instr_err_i ? st_fetch_req : st_store_req;
      end
      st_store_req: begin
        if (data_gnt_i) state_d = st_store_wait;
      end
      default: begin
        if (data_rvalid_i) state_d = st_fetch_req;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= st_fetch_req;
      pc_q         <= `LS_BOOT_ADDR;
      fetch_addr_q <= '0;
      wdata_q      <= '0;
    end else begin
      state_q <= state_d;
      if (fetch_req && instr_gnt_i) begin
        pc_q         <= pc_q + `LS_XLEN'(4);
        fetch_addr_q <= pc_q;
      end
      if (fetch_ok) wdata_q <= instr_rdata_i;
    end
  end

  assign bus.instr_req  = fetch_req;
  assign bus.instr_addr = pc_q;
  assign bus.data_req   = store_req;
  assign bus.data_we    = store_req;
  assign bus.data_be    = {(`LS_XLEN/8){store_req}};
  assign bus.data_addr  = fetch_addr_q | `LS_DATA_BASE;
  assign bus.data_wdata = wdata_q;

endmodule

//--- bus_intg_check.sv
/*
 Integrity check of bus read data and check-bit generation for writes.
 Each incoming codeword is multiplied by the parity matrix. A non-zero
 syndrome on a valid response raises the error flag.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module bus_intg_check (
  input  lockstep_pkg::intg_word_u  instr_word_i,
  input  lockstep_pkg::intg_word_u  data_word_i,
  input  logic                      instr_chk_valid_i,
  input  logic                      data_chk_valid_i,
  input  logic [`LS_XLEN-1:0]       data_wdata_i,
  output logic                      intg_err_o,
  output logic [`LS_INTG_W-1:0]     data_wdata_intg_o
);

  logic [`LS_INTG_W-1:0] instr_syn, data_syn;

  // Row i covers check bit i and its data columns
  for (genvar i = 0; i < `LS_INTG_W; i++) begin : g_syn
    localparam logic [`LS_INTG_W+`LS_XLEN-1:0] h_row =
        {`LS_INTG_W'(1 << i), lockstep_pkg::intg_mask[i]};

    assign instr_syn[i] = ^(instr_word_i.raw & h_row);
    assign data_syn[i]  = ^(data_word_i.raw & h_row);
  end

  assign intg_err_o = (instr_chk_valid_i & |instr_syn) |
                      (data_chk_valid_i & |data_syn);

  assign data_wdata_intg_o = lockstep_pkg::intg_encode(data_wdata_i);

endmodule

//--- lockstep_compare.sv
/*
 Output comparator of the lockstep pair.
 Delays the main core's requests by the offset plus one and registers the
 shadow core's requests once, so both line up. Any difference while the
 compare is enabled is flagged.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module lockstep_compare (
  input  logic     clk_i,
  input  logic     rst_ni,
  core_bus_if.cmp  main,
  core_bus_if.cmp  shadow,
  input  logic     cmp_en_i,
  output logic     mismatch_o
);

  // Extra stage matches the shadow output register
  localparam int unsigned out_dly = `LS_OFFSET + 1;
  localparam int unsigned bus_w   = 3 * `LS_XLEN + `LS_XLEN / 8 + 3;

  logic [bus_w-1:0]               main_in, shadow_in, shadow_q;
  logic [out_dly-1:0][bus_w-1:0]  main_q;

  assign main_in = {main.instr_req, main.instr_addr, main.data_req, main.data_we,
                    main.data_be, main.data_addr, main.data_wdata};

  assign shadow_in = {shadow.instr_req, shadow.instr_addr, shadow.data_req, shadow.data_we,
                      shadow.data_be, shadow.data_addr, shadow.data_wdata};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_q   <= '0;
      shadow_q <= '0;
    end else begin
      for (int i = 0; i < out_dly - 1; i++) begin
        main_q[i] <= main_q[i+1];
      end
      main_q[out_dly-1] <= main_in;
      shadow_q          <= shadow_in;
    end
  end

  assign mismatch_o = cmp_en_i & (main_q[0] != shadow_q);

endmodule

//--- lockstep_top.sv
/*
 Dual-core lockstep checker around the fetch-and-store core.
 The main core sits outside; its requests and bus responses come in here.
 A shadow core replays the responses the lockstep offset later and any
 output mismatch or read integrity error raises the major alert.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module lockstep_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_enable_i,
  input  logic                   instr_req_i,
  input  logic [`LS_XLEN-1:0]    instr_addr_i,
  input  logic                   data_req_i,
  input  logic                   data_we_i,
  input  logic [`LS_XLEN/8-1:0]  data_be_i,
  input  logic [`LS_XLEN-1:0]    data_addr_i,
  input  logic [`LS_XLEN-1:0]    data_wdata_i,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [`LS_XLEN-1:0]    instr_rdata_i,
  input  logic [`LS_INTG_W-1:0]  instr_rdata_intg_i,
  input  logic                   instr_err_i,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic [`LS_XLEN-1:0]    data_rdata_i,
  input  logic [`LS_INTG_W-1:0]  data_rdata_intg_i,
  input  logic                   data_err_i,
  output logic [`LS_INTG_W-1:0]  data_wdata_intg_o,
  output logic                   alert_major_o
);

  logic                      rst_shadow_n, cmp_en;
  logic                      instr_gnt_dly, instr_rvalid_dly, instr_err_dly;
  logic [`LS_XLEN-1:0]       instr_rdata_dly;
  logic                      data_gnt_dly, data_rvalid_dly, fetch_enable_dly;
  lockstep_pkg::intg_word_u  instr_word, data_word;
  logic                      instr_chk_valid, data_chk_valid;
  logic                      mismatch, intg_err;

  core_bus_if main_bus ();
  core_bus_if shadow_bus ();

  assign main_bus.instr_req  = instr_req_i;
  assign main_bus.instr_addr = instr_addr_i;
  assign main_bus.data_req   = data_req_i;
  assign main_bus.data_we    = data_we_i;
  assign main_bus.data_be    = data_be_i;
  assign main_bus.data_addr  = data_addr_i;
  assign main_bus.data_wdata = data_wdata_i;

  ////////////////////////////////////////
  // Shadow core and its inputs
  ////////////////////////////////////////

  shadow_reset_ctrl u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rst_shadow_no (rst_shadow_n),
    .cmp_en_o      (cmp_en)
  );

  // Store responses carry nothing the core consumes
  shadow_input_delay u_in_dly (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_gnt_i        (instr_gnt_i),
    .instr_rvalid_i     (instr_rvalid_i),
    .instr_rdata_i      (instr_rdata_i),
    .instr_rdata_intg_i (instr_rdata_intg_i),
    .instr_err_i        (instr_err_i),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_rdata_i       (data_rdata_i),
    .data_rdata_intg_i  (data_rdata_intg_i),
    .data_err_i         (data_err_i),
    .fetch_enable_i     (fetch_enable_i),
    .instr_gnt_dly_o    (instr_gnt_dly),
    .instr_rvalid_dly_o (instr_rvalid_dly),
    .instr_rdata_dly_o  (instr_rdata_dly),
    .instr_err_dly_o    (instr_err_dly),
    .data_gnt_dly_o     (data_gnt_dly),
    .data_rvalid_dly_o  (data_rvalid_dly),
    .data_rdata_dly_o   (),
    .data_err_dly_o     (),
    .fetch_enable_dly_o (fetch_enable_dly),
    .instr_word_o       (instr_word),
    .data_word_o        (data_word),
    .instr_chk_valid_o  (instr_chk_valid),
    .data_chk_valid_o   (data_chk_valid)
  );

  shadow_core u_shadow_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_shadow_n),
    .instr_gnt_i    (instr_gnt_dly),
    .instr_rvalid_i (instr_rvalid_dly),
    .instr_rdata_i  (instr_rdata_dly),
    .instr_err_i    (instr_err_dly),
    .data_gnt_i     (data_gnt_dly),
    .data_rvalid_i  (data_rvalid_dly),
    .fetch_enable_i (fetch_enable_dly),
    .bus            (shadow_bus)
  );

  ////////////////////////////////////////
  // Checks and alert
  ////////////////////////////////////////

  bus_intg_check u_intg_chk (
    .instr_word_i      (instr_word),
    .data_word_i       (data_word),
    .instr_chk_valid_i (instr_chk_valid),
    .data_chk_valid_i  (data_chk_valid),
    .data_wdata_i      (data_wdata_i),
    .intg_err_o        (intg_err),
    .data_wdata_intg_o (data_wdata_intg_o)
  );

  lockstep_compare u_cmp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .main       (main_bus),
    .shadow     (shadow_bus),
    .cmp_en_i   (cmp_en),
    .mismatch_o (mismatch)
  );

  assign alert_major_o = mismatch | intg_err;

endmodule

//--- lockstep_chk.sv
/*
 Concurrent checks on the lockstep checker outputs.
 Bound into lockstep_top, watches the alert, the write check bits and
 the comparator enable.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module lockstep_chk (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  alert_i,
  input logic [`LS_INTG_W-1:0] wdata_intg_i,
  input logic                  cmp_en_i,
  input logic                  rst_shadow_i
);

  int unsigned fail_cnt = 0;

  a_alert_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !alert_i)
    else begin
      fail_cnt++;
      $error("alert_major_o high while rst_ni is low");
    end

  a_known_outputs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({alert_i, wdata_intg_i}))
    else begin
      fail_cnt++;
      $error("alert_major_o or data_wdata_intg_o unknown after reset");
    end

  // Comparator waits one edge after the shadow core leaves reset
  a_cmp_en_after_shadow: assert property (@(posedge clk_i)
    $rose(cmp_en_i) |-> $past(rst_shadow_i))
    else begin
      fail_cnt++;
      $error("compare enabled before the shadow core left reset");
    end

endmodule

bind lockstep_top lockstep_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .alert_i      (alert_major_o),
  .wdata_intg_i (data_wdata_intg_o),
  .cmp_en_i     (cmp_en),
  .rst_shadow_i (rst_shadow_n)
);

//--- tb_lockstep_tests.svh
/*
 Directed tests of the lockstep checker.
 Included into the testbench module; each test steers the main core
 model and the responder and lets the per-cycle driver check the DUT.
*/

`ifndef TB_LOCKSTEP_TESTS_SVH
`define TB_LOCKSTEP_TESTS_SVH

task automatic test_reset_quiet();
  start_test("reset_quiet");
  fetch_en_cfg = 1'b0;
  run_cycles(quiet_cycles);
  finish_test();
endtask

task automatic test_clean_run();
  int stores0;
  start_test("clean_lockstep_run");
  stores0 = store_cnt;
  @(posedge clk_i);
  fetch_en_cfg = 1'b1;
  wait (store_cnt >= stores0 + clean_rounds);
  run_cycles(`LS_OFFSET + 4);
  finish_test();
endtask

// One corrupted write data cycle on the main side
task automatic test_output_divergence();
  start_test("output_divergence");
  run_cycles(3);
  flip_arm = 1'b1;
  wait (!flip_arm);
  run_cycles(`LS_OFFSET + 4);
  finish_test();
endtask

task automatic test_instr_intg_error();
  start_test("instr_intg_error");
  run_cycles(2);
  corrupt_instr_arm = 1'b1;
  wait (!corrupt_instr_arm);
  // Lets the corrupted word go through store and compare
  run_cycles(`LS_OFFSET + 12);
  finish_test();
endtask

task automatic test_data_intg_and_fetch_error();
  start_test("data_intg_and_fetch_error");
  run_cycles(2);
  corrupt_data_arm = 1'b1;
  wait (!corrupt_data_arm);
  run_cycles(6);
  err_instr_arm = 1'b1;
  wait (!err_instr_arm);
  wait (fetch_gnt_cnt > err_gnt_cnt);
  run_cycles(`LS_OFFSET + 10);
  finish_test();
endtask

`endif

//--- tb_lockstep.sv
/*
 Testbench for the lockstep checker.
 A behavioral main core and a bus responder drive the DUT on the falling
 edge. Alert and write check bits are checked every cycle against events
 the tests schedule. Directed tests come from the included test file.
*/

`timescale 1ns/1ps
`include "lockstep_params.svh"

module tb_lockstep;

  localparam int half_period   = 20;
  localparam int reset_cycles  = 5;
  localparam int quiet_cycles  = 20;
  localparam int clean_rounds  = 20;
  localparam int round_cycles  = 10;
  localparam int event_cycles  = 40;
  localparam int budget_cycles = reset_cycles + quiet_cycles + clean_rounds * round_cycles +
                                 3 * event_cycles + 100;

  localparam logic [1:0] st_fetch_req  = 2'd0;
  localparam logic [1:0] st_fetch_wait = 2'd1;
  localparam logic [1:0] st_store_req  = 2'd2;
  localparam logic [1:0] st_store_wait = 2'd3;

  // Hsiao (39,32) parity rows, row i gives check bit i
  localparam logic [31:0] code_rows [7] = '{32'h2606_BD25, 32'hDEBA_8050, 32'h413D_89AA,
                                            32'h3123_4ED1, 32'hC2C1_323B, 32'h2DCC_624C,
                                            32'h9850_5586};

  logic                  clk_i = 1'b0;
  logic                  rst_ni, fetch_enable_i;
  logic                  instr_req_i, data_req_i, data_we_i;
  logic [`LS_XLEN-1:0]   instr_addr_i, data_addr_i, data_wdata_i;
  logic [`LS_XLEN/8-1:0] data_be_i;
  logic                  instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic                  data_gnt_i, data_rvalid_i, data_err_i;
  logic [`LS_XLEN-1:0]   instr_rdata_i, data_rdata_i;
  logic [`LS_INTG_W-1:0] instr_rdata_intg_i, data_rdata_intg_i, data_wdata_intg_o;
  logic                  alert_major_o;

  // Main core model and responder
  logic [1:0]          m_state;
  logic [`LS_XLEN-1:0] m_pc, m_fetch_addr, m_wdata;
  logic                fetch_en_cfg, instr_pend, data_pend;
  logic                flip_arm, corrupt_instr_arm, corrupt_data_arm, err_instr_arm;
  logic [31:0]         lcg_state;
  int                  gnt_wait, edge_cnt, errors, test_err0, tests_run, tests_ok;
  int                  store_cnt, fetch_gnt_cnt, err_gnt_cnt;
  int                  alert_edges[$];
  string               test_name;

  lockstep_top dut_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_enable_i     (fetch_enable_i),
    .instr_req_i        (instr_req_i),
    .instr_addr_i       (instr_addr_i),
    .data_req_i         (data_req_i),
    .data_we_i          (data_we_i),
    .data_be_i          (data_be_i),
    .data_addr_i        (data_addr_i),
    .data_wdata_i       (data_wdata_i),
    .instr_gnt_i        (instr_gnt_i),
    .instr_rvalid_i     (instr_rvalid_i),
    .instr_rdata_i      (instr_rdata_i),
    .instr_rdata_intg_i (instr_rdata_intg_i),
    .instr_err_i        (instr_err_i),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_rdata_i       (data_rdata_i),
    .data_rdata_intg_i  (data_rdata_intg_i),
    .data_err_i         (data_err_i),
    .data_wdata_intg_o  (data_wdata_intg_o),
    .alert_major_o      (alert_major_o)
  );

  always #half_period clk_i = ~clk_i;

  // Edge 1 is the first rising edge after reset release
  always @(posedge clk_i) begin
    if (rst_ni) edge_cnt <= edge_cnt + 1;
  end

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`LS_INTG_W-1:0] intg_of(logic [`LS_XLEN-1:0] word);
    logic [`LS_INTG_W-1:0] chk;
    chk = '0;
    for (int j = 0; j < `LS_XLEN; j++) begin
      if (word[j]) begin
        for (int i = 0; i < `LS_INTG_W; i++) begin
          chk[i] = chk[i] ^ code_rows[i][j];
        end
      end
    end
    return chk;
  endfunction

  task automatic check_bit(string what, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: %s expected %0b actual %0b", test_name, what, exp, act);
    end
  endtask

  task automatic check_intg(string what, logic [`LS_INTG_W-1:0] exp,
                            logic [`LS_INTG_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Per-cycle driver, on the falling edge
  ////////////////////////////////////////

  task automatic check_outputs();
    logic exp_alert;
    exp_alert = 1'b0;
    foreach (alert_edges[i]) begin
      if (alert_edges[i] == edge_cnt) exp_alert = 1'b1;
    end
    check_bit("alert_major_o", exp_alert, alert_major_o);
    if (data_req_i) begin
      check_intg("data_wdata_intg_o", intg_of(data_wdata_i), data_wdata_intg_o);
    end
  endtask

  // Acts on what the DUT sampled at the last rising edge
  task automatic advance_model();
    case (m_state)
      st_fetch_req: begin
        if (instr_req_i && instr_gnt_i) begin
          m_fetch_addr    = m_pc;
          m_pc            = m_pc + 32'd4;
          m_state         = st_fetch_wait;
          fetch_gnt_cnt++;
        end
      end
      st_fetch_wait: begin
        if (instr_rvalid_i && instr_err_i) begin
          m_state = st_fetch_req;
        end else if (instr_rvalid_i) begin
          m_wdata = instr_rdata_i;
          m_state = st_store_req;
        end
      end
      st_store_req: begin
        if (data_gnt_i) m_state = st_store_wait;
      end
      default: begin
        if (data_rvalid_i) begin
          m_state = st_fetch_req;
          store_cnt++;
        end
      end
    endcase
  endtask

  task automatic drive_requests();
    instr_req_i  = (m_state == st_fetch_req) && fetch_enable_i;
    instr_addr_i = m_pc;
    data_req_i   = (m_state == st_store_req);
    data_we_i    = data_req_i;
    data_be_i    = {(`LS_XLEN/8){data_req_i}};
    data_addr_i  = m_fetch_addr | `LS_DATA_BASE;
    data_wdata_i = m_wdata;
    if (flip_arm && data_req_i) begin
      data_wdata_i = m_wdata ^ (32'h1 << (rand_next() % 32));
      alert_edges.push_back(edge_cnt + `LS_OFFSET + 1);
      flip_arm = 1'b0;
    end
  endtask

  task automatic drive_responses();
    logic [`LS_XLEN-1:0] word;
    {instr_gnt_i, instr_rvalid_i, instr_err_i} = '0;
    {data_gnt_i, data_rvalid_i, data_err_i}    = '0;
    {instr_rdata_i, instr_rdata_intg_i}        = '0;
    {data_rdata_i, data_rdata_intg_i}          = '0;
    if (instr_pend) begin
      word               = rand_next();
      instr_rvalid_i     = 1'b1;
      instr_rdata_i      = word;
      instr_rdata_intg_i = intg_of(word);
      if (corrupt_instr_arm) begin
        instr_rdata_i = word ^ (32'h1 << (rand_next() % 32));
        alert_edges.push_back(edge_cnt + 1);
        corrupt_instr_arm = 1'b0;
      end else if (err_instr_arm) begin
        instr_err_i   = 1'b1;
        err_gnt_cnt   = fetch_gnt_cnt;
        err_instr_arm = 1'b0;
      end
    end
    if (data_pend) begin
      word              = rand_next();
      data_rvalid_i     = 1'b1;
      data_rdata_i      = word;
      data_rdata_intg_i = intg_of(word);
      if (corrupt_data_arm) begin
        data_rdata_intg_i = data_rdata_intg_i ^ (`LS_INTG_W'(1) << (rand_next() % `LS_INTG_W));
        alert_edges.push_back(edge_cnt + 1);
        corrupt_data_arm = 1'b0;
      end
    end
    instr_pend = 1'b0;
    data_pend  = 1'b0;
    // Grant after 0 to 2 waiting cycles
    if (instr_req_i || data_req_i) begin
      if (gnt_wait < 0) gnt_wait = rand_next() % 3;
      if (gnt_wait == 0) begin
        instr_gnt_i = instr_req_i;
        data_gnt_i  = data_req_i;
        instr_pend  = instr_req_i;
        data_pend   = data_req_i;
        gnt_wait    = -1;
      end else begin
        gnt_wait--;
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (edge_cnt != 0) begin
      check_outputs();
      advance_model();
      fetch_enable_i = fetch_en_cfg;
      drive_requests();
      drive_responses();
    end
  end

  task automatic init_inputs();
    rst_ni         = 1'b0;
    fetch_en_cfg   = 1'b0;
    fetch_enable_i = 1'b0;
    {m_state, m_pc, m_fetch_addr, m_wdata} = {st_fetch_req, `LS_BOOT_ADDR, 64'h0};
    {instr_pend, data_pend, flip_arm, corrupt_instr_arm} = '0;
    {corrupt_data_arm, err_instr_arm} = '0;
    lcg_state = 32'd85566;
    gnt_wait  = -1;
    {edge_cnt, errors, tests_run, tests_ok} = '0;
    {store_cnt, fetch_gnt_cnt, err_gnt_cnt} = '0;
    drive_requests();
    drive_responses();
  endtask

  task automatic run_cycles(int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_err0) begin
      tests_ok++;
      $display("done %s: ok", test_name);
    end else begin
      $display("done %s: %0d errors", test_name, errors - test_err0);
    end
  endtask

  `include "tb_lockstep_tests.svh"

  initial begin
    #(budget_cycles * 2 * half_period);
    $display("watchdog: no result after %0d cycles", budget_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    test_name = "reset";
    init_inputs();
    repeat (reset_cycles) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_quiet();
    test_clean_run();
    test_output_divergence();
    test_instr_intg_error();
    test_data_intg_and_fetch_error();
    errors += int'(dut_i.u_chk.fail_cnt);
    $display("tests %0d, passed %0d, errors %0d", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- lockstep_top.f
+incdir+.
lockstep_pkg.sv
core_bus_if.sv
shadow_reset_ctrl.sv
shadow_input_delay.sv
shadow_core.sv
bus_intg_check.sv
lockstep_compare.sv
lockstep_top.sv
lockstep_chk.sv
tb_lockstep.sv
